/* hw/cpuPkg.sv */
package cpuPkg;

    // Word and register file sizes
    localparam int dataWidth    = 16;
    localparam int regCount     = 16;
    localparam int regAddrWidth = $clog2(regCount);

    // Major opcodes in bits 15 to 12, anything else is a no-op
    localparam logic [3:0] opAluReg    = 4'd0;
    localparam logic [3:0] opAddImm    = 4'd1;
    localparam logic [3:0] opLoadImm   = 4'd2;
    localparam logic [3:0] opLoadUpper = 4'd3;
    localparam logic [3:0] opJumpLink  = 4'd4;

    // ALU minor codes, 9 to 15 behave like aluPassB
    localparam logic [3:0] aluAdd   = 4'd0;
    localparam logic [3:0] aluSub   = 4'd1;
    localparam logic [3:0] aluAnd   = 4'd2;
    localparam logic [3:0] aluOr    = 4'd3;
    localparam logic [3:0] aluXor   = 4'd4;
    localparam logic [3:0] aluShl   = 4'd5;
    localparam logic [3:0] aluShr   = 4'd6;
    localparam logic [3:0] aluSltu  = 4'd7;
    localparam logic [3:0] aluPassB = 4'd8;

    // Register form: A op B
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] regA;
        logic [3:0] regB;
        logic [3:0] minor;
    } regFormT;

    // Immediate form shares opcode and regA with the register form
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] regA;
        logic [7:0] imm8;
    } immFormT;

    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrWordT;

    typedef enum logic {
        wbAlu  = 1'b0,
        wbLink = 1'b1
    } wbSrcT;

endpackage

/* hw/pipeControl.sv */
module pipeControl (
    input  logic clk,
    input  logic rst,
    input  logic systemEn,
    input  logic jumpTaken,
    output logic squash
);

    // Low is run, high is flush
    logic inFlush;
    logic inFlushNext;

    always_comb begin
        inFlushNext = inFlush;
        if (systemEn) begin
            if (inFlush) begin
                // Wrong-path word has been dropped
                inFlushNext = 1'b0;
            end else if (jumpTaken) begin
                inFlushNext = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlush <= 1'b0;
        end else begin
            inFlush <= inFlushNext;
        end
    end

    // Invalidates the word fetched alongside the jump
    assign squash = inFlush;

    // Squashed word never resolves a jump
    noJumpInFlush: assert property (
        @(posedge clk) disable iff (rst)
        inFlush |-> !jumpTaken
    );

endmodule

/* hw/programCounter.sv */
module programCounter import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 systemEn,
    input  logic                 jumpTaken,
    input  logic [dataWidth-1:0] jumpDest,
    output logic [dataWidth-1:0] instrAddr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            instrAddr <= '0;
        end else if (systemEn) begin
            if (jumpTaken) begin
                instrAddr <= jumpDest;
            end else begin
                // Wraps at 16 bits
                instrAddr <= instrAddr + 1'b1;
            end
        end
    end

    // A taken jump needs a known target from the register file
    jumpDestKnown: assert property (
        @(posedge clk) disable iff (rst)
        (systemEn && jumpTaken) |-> !$isunknown(jumpDest)
    );

endmodule

/* hw/decodeStage.sv */
module decodeStage import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    systemEn,
    input  logic                    squash,
    input  logic [dataWidth-1:0]    instr,
    input  logic [dataWidth-1:0]    readDataA,
    input  logic [dataWidth-1:0]    readDataB,
    output logic [regAddrWidth-1:0] readAddrA,
    output logic [regAddrWidth-1:0] readAddrB,
    output logic                    jumpTaken,
    output logic [dataWidth-1:0]    jumpDest,
    output logic                    decodeValid,
    output logic [regAddrWidth-1:0] destAddr,
    output logic                    regWrite,
    output wbSrcT                   wbSrc,
    output logic [3:0]              minor,
    output logic [dataWidth-1:0]    operandA,
    output logic [dataWidth-1:0]    operandB
);

    instrWordT  fetchWord;
    logic       fetchValid;
    logic [3:0] opcode;
    logic [7:0] imm8;

    // Fetch buffer payload
    always_ff @(posedge clk) begin
        if (systemEn) begin
            fetchWord <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchValid <= 1'b0;
        end else if (systemEn) begin
            fetchValid <= 1'b1;
        end
    end

    // Same word seen as register form and immediate form
    assign opcode    = fetchWord.regForm.opcode;
    assign imm8      = fetchWord.immForm.imm8;
    assign readAddrA = fetchWord.regForm.regA;
    assign readAddrB = fetchWord.regForm.regB;
    assign destAddr  = fetchWord.regForm.regA;

    assign decodeValid = fetchValid && !squash;
    assign regWrite    = (opcode <= opJumpLink);
    assign wbSrc       = (opcode == opJumpLink) ? wbLink : wbAlu;

    // Jump resolves here, target comes straight from register B
    assign jumpTaken = decodeValid && (opcode == opJumpLink);
    assign jumpDest  = readDataB;

    assign operandA = readDataA;

    // Immediate mux for operand B
    always_comb begin
        operandB = readDataB;
        minor    = aluPassB;
        case (opcode)
            opAluReg: begin
                minor = fetchWord.regForm.minor;
            end
            opAddImm: begin
                operandB = {{(dataWidth - 8){imm8[7]}}, imm8};
                minor    = aluAdd;
            end
            opLoadImm: begin
                operandB = {{(dataWidth - 8){1'b0}}, imm8};
            end
            opLoadUpper: begin
                // Low byte of A survives
                operandB = {imm8, readDataA[7:0]};
            end
            default: begin
                minor = aluPassB;
            end
        endcase
    end

endmodule

/* hw/registerFile.sv */
module registerFile import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    input  logic                    writeEn,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB
);

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Writeback bypass into decode
    always_comb begin
        readDataA = regs[readAddrA];
        readDataB = regs[readAddrB];
        if (writeEn && (writeAddr == readAddrA)) begin
            readDataA = writeData;
        end
        if (writeEn && (writeAddr == readAddrB)) begin
            readDataB = writeData;
        end
    end

    // Execute stage must present a clean address with every strobe
    writeAddrKnown: assert property (
        @(posedge clk) disable iff (rst)
        writeEn |-> !$isunknown(writeAddr)
    );

endmodule

/* hw/executeStage.sv */
module executeStage import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    systemEn,
    input  logic                    decodeValid,
    input  logic [regAddrWidth-1:0] destAddr,
    input  logic                    regWrite,
    input  wbSrcT                   wbSrc,
    input  logic [3:0]              minor,
    input  logic [dataWidth-1:0]    operandA,
    input  logic [dataWidth-1:0]    operandB,
    input  logic [dataWidth-1:0]    instrAddr,
    output logic                    writeEn,
    output logic [regAddrWidth-1:0] writeAddr,
    output logic [dataWidth-1:0]    writeData
);

    // Issue buffer control bits
    logic                    issueValid;
    logic                    issueRegWrite;

    // Issue buffer payload
    logic [regAddrWidth-1:0] issueDest;
    wbSrcT                   issueWbSrc;
    logic [3:0]              issueMinor;
    logic [dataWidth-1:0]    issueA;
    logic [dataWidth-1:0]    issueB;
    logic [dataWidth-1:0]    issueLink;

    logic [dataWidth-1:0]    aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid    <= 1'b0;
            issueRegWrite <= 1'b0;
        end else if (systemEn) begin
            issueValid    <= decodeValid;
            issueRegWrite <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (systemEn) begin
            issueDest  <= destAddr;
            issueWbSrc <= wbSrc;
            issueMinor <= minor;
            issueA     <= operandA;
            issueB     <= operandB;
            // PC already points one past the jump
            if (wbSrc == wbLink) begin
                issueLink <= instrAddr;
            end
        end
    end

    always_comb begin
        case (issueMinor)
            aluAdd:  aluResult = issueA + issueB;
            aluSub:  aluResult = issueA - issueB;
            aluAnd:  aluResult = issueA & issueB;
            aluOr:   aluResult = issueA | issueB;
            aluXor:  aluResult = issueA ^ issueB;
            aluShl:  aluResult = issueA << issueB[3:0];
            aluShr:  aluResult = issueA >> issueB[3:0];
            aluSltu: aluResult = {{(dataWidth - 1){1'b0}}, (issueA < issueB)};
            // aluPassB and the unused codes above it
            default: aluResult = issueB;
        endcase
    end

    // Writeback mux
    assign writeData = (issueWbSrc == wbLink) ? issueLink : aluResult;
    assign writeAddr = issueDest;

    // No strobe while frozen
    assign writeEn = issueValid && issueRegWrite && systemEn;

endmodule

/* hw/cpuTop.sv */
module cpuTop import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    systemEn,
    output logic [dataWidth-1:0]    instrAddr,
    input  logic [dataWidth-1:0]    instr,
    output logic                    writeEn,
    output logic [regAddrWidth-1:0] writeAddr,
    output logic [dataWidth-1:0]    writeData
);

    logic                    squash;
    logic                    jumpTaken;
    logic [dataWidth-1:0]    jumpDest;

    // Decode to register file
    logic [regAddrWidth-1:0] readAddrA;
    logic [regAddrWidth-1:0] readAddrB;
    logic [dataWidth-1:0]    readDataA;
    logic [dataWidth-1:0]    readDataB;

    // Decode to execute
    logic                    decodeValid;
    logic [regAddrWidth-1:0] destAddr;
    logic                    regWrite;
    wbSrcT                   wbSrc;
    logic [3:0]              minor;
    logic [dataWidth-1:0]    operandA;
    logic [dataWidth-1:0]    operandB;

    pipeControl uPipeControl (
        .clk       (clk),
        .rst       (rst),
        .systemEn  (systemEn),
        .jumpTaken (jumpTaken),
        .squash    (squash)
    );

    programCounter uProgramCounter (
        .clk       (clk),
        .rst       (rst),
        .systemEn  (systemEn),
        .jumpTaken (jumpTaken),
        .jumpDest  (jumpDest),
        .instrAddr (instrAddr)
    );

    decodeStage uDecodeStage (
        .clk         (clk),
        .rst         (rst),
        .systemEn    (systemEn),
        .squash      (squash),
        .instr       (instr),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .readAddrA   (readAddrA),
        .readAddrB   (readAddrB),
        .jumpTaken   (jumpTaken),
        .jumpDest    (jumpDest),
        .decodeValid (decodeValid),
        .destAddr    (destAddr),
        .regWrite    (regWrite),
        .wbSrc       (wbSrc),
        .minor       (minor),
        .operandA    (operandA),
        .operandB    (operandB)
    );

    registerFile uRegisterFile (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    executeStage uExecuteStage (
        .clk         (clk),
        .rst         (rst),
        .systemEn    (systemEn),
        .decodeValid (decodeValid),
        .destAddr    (destAddr),
        .regWrite    (regWrite),
        .wbSrc       (wbSrc),
        .minor       (minor),
        .operandA    (operandA),
        .operandB    (operandB),
        .instrAddr   (instrAddr),
        .writeEn     (writeEn),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

endmodule

/* verif/isaModel.svh */
// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// One LFSR step per bit taken
task automatic randomBits(input int count, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsrState = nextLfsr(lfsrState);
        value = {value[14:0], lfsrState[0]};
    end
endtask

task automatic checkEqual(input logic [15:0] actual, input logic [15:0] expected,
                          input string what);
    if (actual !== expected) begin
        $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
        $display("TB FAILED");
        $fatal(1, "Mismatch on %s", what);
    end
endtask

// Reference ALU by minor code
function automatic logic [15:0] aluModel(input logic [3:0] code, input logic [15:0] a,
                                         input logic [15:0] b);
    case (code)
        aluAdd:  return a + b;
        aluSub:  return a - b;
        aluAnd:  return a & b;
        aluOr:   return a | b;
        aluXor:  return a ^ b;
        aluShl:  return a << b[3:0];
        aluShr:  return a >> b[3:0];
        aluSltu: return (a < b) ? 16'd1 : 16'd0;
        default: return b;
    endcase
endfunction

// Runs the program until the next register write and returns it
task automatic modelNextWrite(output logic [3:0] addr, output logic [15:0] data);
    logic [15:0] word;
    logic [15:0] a;
    logic [15:0] b;
    logic [7:0]  imm;
    logic        found;
    int          steps;
    found = 1'b0;
    steps = 0;
    addr = '0;
    data = '0;
    while (!found && steps <= 256) begin
        word = imem[modelPc[7:0]];
        imm = word[7:0];
        a = modelRegs[word[11:8]];
        b = modelRegs[word[7:4]];
        addr = word[11:8];
        found = 1'b1;
        case (word[15:12])
            opAluReg:    data = aluModel(word[3:0], a, b);
            opAddImm:    data = a + {{8{imm[7]}}, imm};
            opLoadImm:   data = {8'h00, imm};
            opLoadUpper: data = {imm, a[7:0]};
            opJumpLink:  data = modelPc + 16'd1;
            default:     found = 1'b0;
        endcase
        // B was read above, before A changes
        modelPc = (word[15:12] == opJumpLink) ? b : modelPc + 16'd1;
        if (found) begin
            modelRegs[addr] = data;
        end
        steps++;
    end
    if (!found) begin
        $display("Model found no register write in a full pass over memory");
        $display("TB FAILED");
        $fatal(1, "Program without writes");
    end
endtask

/* verif/tbCpu.sv */
module tbCpu import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int halfPeriod     = 4;
    localparam int resetCycles    = 3;
    localparam int writeTarget    = 400;
    localparam int cyclesPerWrite = 8;

    logic        clk = 1'b0;
    logic        rst;
    logic        systemEn;
    logic [15:0] instrAddr;
    logic [15:0] instr;
    logic        writeEn;
    logic [3:0]  writeAddr;
    logic [15:0] writeData;

    logic [15:0] imem [256];
    logic [31:0] lfsrState = 32'he158_7c89;
    logic [15:0] modelRegs [16];
    logic [15:0] modelPc;

    int          writeCount = 0;
    int          advanceCount = 0;
    logic        prevEn = 1'b1;
    logic [15:0] prevAddr;

    `include "isaModel.svh"

    cpuTop u_dut (
        .clk       (clk),
        .rst       (rst),
        .systemEn  (systemEn),
        .instrAddr (instrAddr),
        .instr     (instr),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

    // Asynchronous instruction memory
    assign instr = imem[instrAddr[7:0]];

    always #halfPeriod clk = ~clk;

    initial begin
        logic [15:0] word;
        rst = 1'b1;
        systemEn = 1'b0;
        modelPc = '0;
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            randomBits(16, word);
            imem[i] = word;
        end
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

    // Enable high in three of four cycles
    always @(posedge clk) begin
        logic [15:0] bits;
        randomBits(2, bits);
        systemEn <= (bits[1:0] != 2'b00);
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        logic [3:0]  expAddr;
        logic [15:0] expData;
        if (!rst) begin
            if (advanceCount == 0) begin
                checkEqual(instrAddr, 16'h0000, "instrAddr after reset");
            end
            if (advanceCount < 2 || !systemEn) begin
                checkEqual({15'h0000, writeEn}, 16'h0000, "writeEn");
            end
            if (!prevEn) begin
                checkEqual(instrAddr, prevAddr, "instrAddr while frozen");
            end
            if (writeEn) begin
                modelNextWrite(expAddr, expData);
                checkEqual({12'h000, writeAddr}, {12'h000, expAddr}, "writeAddr");
                checkEqual(writeData, expData, "writeData");
                writeCount++;
                if (writeCount == writeTarget) begin
                    $display("%0d writes matched the model", writeCount);
                    $display("TB PASSED");
                    $finish;
                end
            end
            if (systemEn) begin
                advanceCount++;
            end
            prevEn = systemEn;
            prevAddr = instrAddr;
        end
    end

    // Watchdog sized from the write target
    initial begin
        #((writeTarget * cyclesPerWrite + resetCycles) * 2 * halfPeriod);
        $display("Timeout: only %0d of %0d writes seen", writeCount, writeTarget);
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* filelist.f */
+incdir+verif
hw/cpuPkg.sv
hw/pipeControl.sv
hw/programCounter.sv
hw/decodeStage.sv
hw/registerFile.sv
hw/executeStage.sv
hw/cpuTop.sv
verif/tbCpu.sv

/* Makefile */
# Verilator build and run for the three-stage core

SIM      ?= verilator
TOP      ?= tbCpu
FILELIST ?= filelist.f
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
BUILDDIR ?= obj_dir
LOG      ?= sim.log

SOURCES  := $(wildcard hw/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILDDIR)/V$(TOP)

$(BUILDDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

# The simulator status is ignored, the log decides
run: compile
	-./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
